// ==== tests/motor_trace.txt ====
# T id busy ncmd cmd_bytes(hex) nack ack_bytes(hex) hi0 per0 hi1 per1 dir0 dir1
# hi and per are clock counts, dir is 2 fwd, 1 rev, 0 stop
# Reset state, no commands
T 1 0 0 0 0 20 0 20 0 0
# PSC 1, CCR 9, motor 0 +4, motor 1 -6
T 2 0 12 CC 00 01 DD 00 09 AA 00 04 BB FF FA 4 CC DD AA BB 8 20 12 20 2 1
# Duty +50 clamps to CCR 9
T 3 0 3 AA 00 32 1 AA 18 20 12 20 2 1
# Unknown header 55 is skipped
T 4 0 4 55 BB 00 03 1 BB 18 20 6 20 2 2
# Random busy, motor 0 -2, motor 1 +5, PSC 3
T 5 1 9 AA FF FE BB 00 05 CC 00 03 3 AA BB CC 8 40 20 40 1 2
# Zero duty on both motors
T 6 0 6 AA 00 00 BB 00 00 2 AA BB 0 40 0 40 0 0

// ==== tb.f ====
rtl/motor_pkg.sv
rtl/motor_cmd_parser.sv
rtl/pwm_channel.sv
rtl/motor_ctrl_top.sv
tests/tb_checker.sv
tests/tb_assertions.sv
tests/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_top
FILELIST  ?= tb.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import motor_pkg::*;

    localparam int max_tests = 16;
    localparam int max_acks  = 8;

    logic                    clk;
    logic                    rst_n;
    logic [byte_w-1:0]       cmd_data;
    logic                    cmd_valid;
    logic                    tx_busy;
    logic [byte_w-1:0]       ack_data;
    logic                    ack_valid;
    logic [n_motors-1:0]     pwm_out;
    logic [2*n_motors-1:0]   motor_dir;

    // Expected values handed to the checker
    logic                    check_req;
    logic                    check_done;
    logic                    all_done;
    int                      exp_id;
    int                      exp_nack;
    logic [byte_w-1:0]       exp_ack [max_acks];
    int                      exp_hi [n_motors];
    int                      exp_per [n_motors];
    logic [1:0]              exp_dir [n_motors];
    int                      err_count;

    // Trace contents
    int                      n_tests;
    int                      t_id [max_tests];
    int                      t_busy [max_tests];
    int                      t_ncmd [max_tests];
    int                      t_nack [max_tests];
    logic [byte_w-1:0]       ack_tab [max_tests][max_acks];
    int                      hi_tab [max_tests][n_motors];
    int                      per_tab [max_tests][n_motors];
    int                      dir_tab [max_tests][n_motors];
    logic [byte_w-1:0]       cmd_q [$];
    logic                    trace_ok;
    int                      wd_limit;
    logic                    wd_armed;

    logic                    busy_mode;
    logic [31:0]             rng;

    motor_ctrl_top u_motor_ctrl_top (.*);

    tb_checker u_checker (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        begin
            x = s;
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
            return x;
        end
    endfunction

    always #10 clk = ~clk;

    // Back-pressure on the acknowledge side
    always @(negedge clk) begin
        if (busy_mode) begin
            rng     = xorshift32(rng);
            tx_busy = rng[4];
        end else begin
            tx_busy = 1'b0;
        end
    end

    task automatic load_trace(output logic ok);
        int    fd;
        int    r;
        int    v;
        string tok;
        string rest;
        begin
            ok      = 1'b0;
            n_tests = 0;
            fd = $fopen("tests/motor_trace.txt", "r");
            if (fd != 0) begin
                ok = 1'b1;
                while ($fscanf(fd, "%s", tok) == 1) begin
                    if (tok == "#") begin
                        r = $fgets(rest, fd);   // Comment line
                    end else if (tok == "T" && n_tests < max_tests) begin
                        r = $fscanf(fd, "%d %d %d", t_id[n_tests], t_busy[n_tests],
                                    t_ncmd[n_tests]);
                        for (int i = 0; i < t_ncmd[n_tests]; i++) begin
                            r = $fscanf(fd, "%h", v);
                            cmd_q.push_back(v[7:0]);
                        end
                        r = $fscanf(fd, "%d", t_nack[n_tests]);
                        for (int i = 0; i < t_nack[n_tests]; i++) begin
                            r = $fscanf(fd, "%h", v);
                            ack_tab[n_tests][i] = v[7:0];
                        end
                        for (int m = 0; m < n_motors; m++) begin
                            r = $fscanf(fd, "%d %d", hi_tab[n_tests][m], per_tab[n_tests][m]);
                        end
                        for (int m = 0; m < n_motors; m++) begin
                            r = $fscanf(fd, "%d", dir_tab[n_tests][m]);
                        end
                        n_tests++;
                    end else begin
                        ok = 1'b0;
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    // One byte, then hold off while an acknowledge is still pending
    task automatic send_byte(input logic [byte_w-1:0] b);
        begin
            @(negedge clk);
            cmd_data  = b;
            cmd_valid = 1'b1;
            @(negedge clk);
            cmd_valid = 1'b0;
            while (ack_valid) begin
                @(negedge clk);
            end
        end
    endtask

    // Ends a run that stops making progress
    initial begin
        wait (wd_armed);
        #(wd_limit);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        int pos;
        int maxper;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_data  = '0;
        cmd_valid = 1'b0;
        tx_busy   = 1'b0;
        busy_mode = 1'b0;
        rng       = 32'h320a;
        check_req = 1'b0;
        all_done  = 1'b0;
        wd_armed  = 1'b0;
        wd_limit  = 0;
        exp_id    = 0;
        exp_nack  = 0;
        for (int i = 0; i < max_acks; i++) begin
            exp_ack[i] = '0;
        end
        for (int m = 0; m < n_motors; m++) begin
            exp_hi[m]  = 0;
            exp_per[m] = 0;
            exp_dir[m] = dir_stop;
        end
        load_trace(trace_ok);
        if (!trace_ok || n_tests == 0) begin
            $display("Trace file missing or malformed");
            $display("Test failed");
            $finish;
        end else begin
            wd_limit = 20000;
            for (int t = 0; t < n_tests; t++) begin
                wd_limit += 4 * 20 * (t_ncmd[t] + 4 * per_tab[t][0] + 4 * per_tab[t][1]);
            end
            wd_armed = 1'b1;
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;

            pos = 0;
            for (int t = 0; t < n_tests; t++) begin
                busy_mode = (t_busy[t] != 0);
                for (int i = 0; i < t_ncmd[t]; i++) begin
                    send_byte(cmd_q[pos]);
                    pos++;
                end
                busy_mode = 1'b0;
                maxper = (per_tab[t][0] > per_tab[t][1]) ? per_tab[t][0] : per_tab[t][1];
                repeat (3 * maxper) @(negedge clk);   // New duty settles at a period start
                exp_id   = t_id[t];
                exp_nack = t_nack[t];
                for (int i = 0; i < max_acks; i++) begin
                    exp_ack[i] = ack_tab[t][i];
                end
                for (int m = 0; m < n_motors; m++) begin
                    exp_hi[m]  = hi_tab[t][m];
                    exp_per[m] = per_tab[t][m];
                    exp_dir[m] = dir_tab[t][m][1:0];
                end
                check_req = 1'b1;
                wait (check_done);
                @(negedge clk);
                check_req = 1'b0;
                wait (!check_done);
            end

            all_done = 1'b1;
            #1;
            if (err_count == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

// ==== tests/tb_assertions.sv ====
`timescale 1ns/1ps

module tb_assertions (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic [motor_pkg::byte_w-1:0]         ack_data,
    input logic                                 ack_valid,
    input logic                                 tx_busy,
    input logic [2*motor_pkg::n_motors-1:0]     motor_dir
);
    import motor_pkg::*;

    // Held byte must not move while the sink is busy
    a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ack_valid && tx_busy |=> ack_valid && $stable(ack_data))
        else $error("ack_data or ack_valid changed while tx_busy was high");

    a_ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
        ack_valid && !tx_busy |=> !ack_valid)
        else $error("ack_valid stayed high after a transfer");

    // Both bridge legs on would short the supply
    for (genvar i = 0; i < n_motors; i++) begin : g_dir
        a_dir_legal: assert property (@(posedge clk) disable iff (!rst_n)
            motor_dir[2*i +: 2] != 2'b11)
            else $error("motor_dir of motor %0d is 2'b11", i);
    end

endmodule

bind motor_ctrl_top tb_assertions u_tb_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .ack_data  (ack_data),
    .ack_valid (ack_valid),
    .tx_busy   (tx_busy),
    .motor_dir (motor_dir)
);

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [motor_pkg::byte_w-1:0]         ack_data,
    input  logic                                 ack_valid,
    input  logic                                 tx_busy,
    input  logic [motor_pkg::n_motors-1:0]       pwm_out,
    input  logic [2*motor_pkg::n_motors-1:0]     motor_dir,
    input  logic                                 check_req,
    input  logic                                 all_done,
    input  int                                   exp_id,
    input  int                                   exp_nack,
    input  logic [motor_pkg::byte_w-1:0]         exp_ack [8],
    input  int                                   exp_hi [motor_pkg::n_motors],
    input  int                                   exp_per [motor_pkg::n_motors],
    input  logic [1:0]                           exp_dir [motor_pkg::n_motors],
    output logic                                 check_done,
    output int                                   err_count
);
    import motor_pkg::*;

    logic [byte_w-1:0] got_q [$];
    int                tests_run;
    int                tests_failed;

    // Every transferred acknowledge, in order
    always @(posedge clk) begin
        if (rst_n && ack_valid && !tx_busy) begin
            got_q.push_back(ack_data);
        end
    end

    always @(posedge all_done) begin
        $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
    end

    initial begin
        int         errs;
        int         maxper;
        int         hi_cnt [n_motors];
        int         rise1 [n_motors];
        int         rise2 [n_motors];
        logic       prev [n_motors];
        logic       cur;
        logic [1:0] dir;
        check_done   = 1'b0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        forever begin
            wait (check_req);
            errs   = 0;
            maxper = (exp_per[0] > exp_per[1]) ? exp_per[0] : exp_per[1];
            for (int m = 0; m < n_motors; m++) begin
                hi_cnt[m] = 0;
                rise1[m]  = -1;
                rise2[m]  = -1;
                prev[m]   = pwm_out[m];
            end
            // High count over one period window, period from two rising edges
            for (int c = 0; c < 3 * maxper; c++) begin
                @(posedge clk);
                for (int m = 0; m < n_motors; m++) begin
                    cur = pwm_out[m];
                    if (c < exp_per[m] && cur) begin
                        hi_cnt[m]++;
                    end
                    if (cur && !prev[m]) begin
                        if (rise1[m] < 0) begin
                            rise1[m] = c;
                        end else if (rise2[m] < 0) begin
                            rise2[m] = c;
                        end
                    end
                    prev[m] = cur;
                end
            end
            for (int m = 0; m < n_motors; m++) begin
                if (hi_cnt[m] != exp_hi[m]) begin
                    $display("** Error: pwm_out[%0d] high count expected 0x%h got 0x%h",
                             m, exp_hi[m], hi_cnt[m]);
                    errs++;
                end
                if (exp_hi[m] > 0 && exp_hi[m] < exp_per[m]) begin
                    if (rise2[m] < 0) begin
                        $display("pwm_out[%0d] did not toggle twice in the window", m);
                        errs++;
                    end else if (rise2[m] - rise1[m] != exp_per[m]) begin
                        $display("** Error: pwm_out[%0d] period expected 0x%h got 0x%h",
                                 m, exp_per[m], rise2[m] - rise1[m]);
                        errs++;
                    end
                end
                dir = motor_dir[2*m +: 2];
                if (dir !== exp_dir[m]) begin
                    $display("** Error: motor_dir[%0d] expected 0x%h got 0x%h",
                             m, exp_dir[m], dir);
                    errs++;
                end
            end
            if (got_q.size() != exp_nack) begin
                $display("Expected %0d acknowledges but received %0d", exp_nack, got_q.size());
                errs++;
            end
            for (int i = 0; i < exp_nack && i < got_q.size(); i++) begin
                if (got_q[i] !== exp_ack[i]) begin
                    $display("** Error: ack_data #%0d expected 0x%h got 0x%h",
                             i, exp_ack[i], got_q[i]);
                    errs++;
                end
            end
            if (ack_valid !== 1'b0) begin
                $display("An acknowledge is still pending at the end of the test");
                errs++;
            end
            tests_run++;
            err_count += errs;
            if (errs == 0) begin
                $display("Test %0d: pass", exp_id);
            end else begin
                tests_failed++;
                $display("Test %0d: FAIL with %0d errors", exp_id, errs);
            end
            @(negedge clk);
            got_q.delete();
            check_done = 1'b1;
            wait (!check_req);
            check_done = 1'b0;
        end
    end

endmodule

// ==== rtl/motor_ctrl_top.sv ====
`timescale 1ns/1ps

module motor_ctrl_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [motor_pkg::byte_w-1:0]       cmd_data,
    input  logic                               cmd_valid,
    input  logic                               tx_busy,
    output logic [motor_pkg::byte_w-1:0]       ack_data,
    output logic                               ack_valid,
    output logic [motor_pkg::n_motors-1:0]     pwm_out,
    output logic [2*motor_pkg::n_motors-1:0]   motor_dir
);
    import motor_pkg::*;

    duty_t duty_bus [n_motors];   // One signed duty per channel
    cfg_t  psc;
    cfg_t  ccr;

    motor_cmd_parser u_motor_cmd_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_data  (cmd_data),
        .cmd_valid (cmd_valid),
        .tx_busy   (tx_busy),
        .ack_data  (ack_data),
        .ack_valid (ack_valid),
        .duty      (duty_bus),
        .psc       (psc),
        .ccr       (ccr)
    );

    // Channels share PSC and CCR, each gets its own duty
    for (genvar i = 0; i < n_motors; i++) begin : g_ch
        pwm_channel u_pwm_channel (
            .clk       (clk),
            .rst_n     (rst_n),
            .duty      (duty_bus[i]),
            .psc       (psc),
            .ccr       (ccr),
            .pwm_out   (pwm_out[i]),
            .motor_dir (motor_dir[2*i +: 2])   // Motor i owns bits 2i+1:2i
        );
    end

endmodule

// ==== rtl/pwm_channel.sv ====
`timescale 1ns/1ps

module pwm_channel (
    input  logic             clk,
    input  logic             rst_n,
    input  motor_pkg::duty_t duty,
    input  motor_pkg::cfg_t  psc,
    input  motor_pkg::cfg_t  ccr,
    output logic             pwm_out,
    output logic [1:0]       motor_dir
);
    import motor_pkg::*;

    cfg_t                   psc_cnt;
    cfg_t                   per_cnt;
    cfg_t                   duty_mag;    // Magnitude in use for this period
    cfg_t                   duty_abs;
    logic signed [duty_w:0] duty_wide;
    logic signed [duty_w:0] duty_neg;
    logic                   tick;
    logic                   period_end;

    // Compare with >= so a smaller PSC or CCR takes hold at once
    assign tick       = (psc_cnt >= psc);
    assign period_end = tick && (per_cnt >= ccr);

    // 17 bits so that -32768 still has a magnitude
    assign duty_wide = {duty[duty_w-1], duty};
    assign duty_neg  = -duty_wide;
    assign duty_abs  = duty[duty_w-1] ? duty_neg[duty_w-1:0] : duty_wide[duty_w-1:0];

    // Prescaler ticks once every psc+1 clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psc_cnt <= '0;
        end else if (tick) begin
            psc_cnt <= '0;
        end else begin
            psc_cnt <= psc_cnt + cfg_t'(1);
        end
    end

    // Period counter 0..ccr
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            per_cnt <= '0;
        end else if (period_end) begin
            per_cnt <= '0;
        end else if (tick) begin
            per_cnt <= per_cnt + cfg_t'(1);
        end
    end

    // Duty and direction only change at a period boundary
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            duty_mag  <= '0;
            motor_dir <= dir_stop;
        end else if (period_end) begin
            duty_mag <= duty_abs;
            if (duty == '0) begin
                motor_dir <= dir_stop;
            end else if (duty[duty_w-1]) begin
                motor_dir <= dir_rev;
            end else begin
                motor_dir <= dir_fwd;
            end
        end
    end

    // High for |duty| counts of each period
    assign pwm_out = (per_cnt < duty_mag);

endmodule

// ==== rtl/motor_cmd_parser.sv ====
`timescale 1ns/1ps

module motor_cmd_parser (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [motor_pkg::byte_w-1:0]  cmd_data,
    input  logic                          cmd_valid,
    input  logic                          tx_busy,
    output logic [motor_pkg::byte_w-1:0]  ack_data,
    output logic                          ack_valid,
    output motor_pkg::duty_t              duty [motor_pkg::n_motors],
    output motor_pkg::cfg_t               psc,
    output motor_pkg::cfg_t               ccr
);
    import motor_pkg::*;

    typedef enum logic [1:0] {
        st_header,
        st_high,
        st_low
    } state_t;

    state_t               state;
    logic [byte_w-1:0]    cur_hdr;       // Header of the command in flight
    logic [byte_w-1:0]    high_byte;
    logic [duty_w-1:0]    word;          // Payload assembled on the low byte
    duty_t                duty_clamped;
    logic                 hdr_known;
    logic                 cmd_done;

    // Limit a requested duty to +/- limit. One extra bit keeps a large
    // unsigned CCR from turning negative in the compare
    function automatic duty_t clamp_duty(input duty_t value, input cfg_t limit);
        logic signed [duty_w:0] wide;
        logic signed [duty_w:0] lim;
        logic signed [duty_w:0] neg_lim;
        duty_t                  result;
        begin
            wide    = {value[duty_w-1], value};
            lim     = $signed({1'b0, limit});
            neg_lim = -lim;
            if (wide > lim) begin
                result = lim[duty_w-1:0];
            end else if (wide < neg_lim) begin
                result = neg_lim[duty_w-1:0];
            end else begin
                result = value;
            end
            return result;
        end
    endfunction

    assign hdr_known = cmd_data inside {hdr_motor0, hdr_motor1, hdr_psc, hdr_ccr};
    assign cmd_done  = cmd_valid && (state == st_low);
    assign word      = {high_byte, cmd_data};

    // Clamp uses the CCR held right now, not one arriving later
    assign duty_clamped = clamp_duty($signed(word), ccr);

    // Byte sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_header;
            cur_hdr <= '0;
        end else if (cmd_valid) begin
            case (state)
                st_header: begin
                    if (hdr_known) begin    // Anything else is skipped
                        cur_hdr <= cmd_data;
                        state   <= st_high;
                    end
                end
                st_high: begin
                    state <= st_low;
                end
                default: begin
                    state <= st_header;     // Low byte closes the command
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && (state == st_high)) begin
            high_byte <= cmd_data;
        end
    end

    // Configuration registers, written on the low byte only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int m = 0; m < n_motors; m++) begin
                duty[m] <= '0;
            end
            psc <= psc_default;
            ccr <= ccr_default;
        end else if (cmd_done) begin
            case (cur_hdr)
                hdr_motor0: duty[0] <= duty_clamped;
                hdr_motor1: duty[1] <= duty_clamped;
                hdr_psc:    psc     <= word;
                hdr_ccr:    ccr     <= word;
                default: begin
                end
            endcase
        end
    end

    // Single-entry acknowledge holding register.
    // A command finishing while a byte is still held loses its ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_valid <= 1'b0;
        end else if (cmd_done && !ack_valid) begin
            ack_valid <= 1'b1;
        end else if (ack_valid && !tx_busy) begin
            ack_valid <= 1'b0;              // Transfer taken this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_done && !ack_valid) begin
            ack_data <= cur_hdr;
        end
    end

endmodule

// ==== rtl/motor_pkg.sv ====
package motor_pkg;

    // Channel count and word sizes
    localparam int n_motors = 2;
    localparam int duty_w   = 16;   // Duty, PSC and CCR all share this width
    localparam int byte_w   = 8;

    // Signed duty as written by the host, unsigned timer settings
    typedef logic signed [duty_w-1:0] duty_t;
    typedef logic        [duty_w-1:0] cfg_t;

    // Command headers. The same byte is echoed back as the acknowledge
    localparam logic [byte_w-1:0] hdr_motor0 = 8'hAA;
    localparam logic [byte_w-1:0] hdr_motor1 = 8'hBB;
    localparam logic [byte_w-1:0] hdr_psc    = 8'hCC;
    localparam logic [byte_w-1:0] hdr_ccr    = 8'hDD;

    // Timer values after reset
    localparam cfg_t psc_default = 16'd99;
    localparam cfg_t ccr_default = 16'd999;

    // H-bridge direction codes, 2'b11 would short the bridge
    localparam logic [1:0] dir_fwd  = 2'b10;
    localparam logic [1:0] dir_rev  = 2'b01;
    localparam logic [1:0] dir_stop = 2'b00;

endpackage
